// ==== logic/cpu_macros.svh ====
// sizing macros for the pipelined core, included by the package and the memory stages
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and address width
`define CPU_XLEN 32

// instruction memory word address width, 64 words
`define CPU_IMEM_AW 6

// data memory word address width, 64 words
`define CPU_DMEM_AW 6

`endif

// ==== logic/cpuPkg.sv ====
// shared opcode, ALU and pipeline register types, imported by every stage of the core
`default_nettype none

`include "cpu_macros.svh"

package cpuPkg;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;  // load data to rd
        logic  memRead;
        logic  memWrite;
        logic  branch;    // beq
        logic  aluSrc;    // immediate as B operand
        aluOpE aluOp;
    } ctrlS;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        logic [31:0]          instr;
    } ifIdS;

    typedef struct packed {
        logic                 valid;
        ctrlS                 ctrl;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] rs1Data;
        logic [`CPU_XLEN-1:0] rs2Data;
        logic [`CPU_XLEN-1:0] imm;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
    } idExS;

    typedef struct packed {
        logic                 valid;
        logic                 regWrite;
        logic                 memToReg;
        logic                 memRead;
        logic                 memWrite;
        logic [`CPU_XLEN-1:0] aluResult;
        logic [`CPU_XLEN-1:0] storeData;  // forwarded rs2
        logic [4:0]           rd;
    } exMemS;

    // also the write-back bus into decode and execute
    typedef struct packed {
        logic                 valid;
        logic                 regWrite;
        logic [4:0]           rd;
        logic [`CPU_XLEN-1:0] wbData;
    } memWbS;

endpackage

`default_nettype wire

// ==== logic/fetchStage.sv ====
// instruction fetch with program counter, loadable instruction memory and the IF/ID register
`default_nettype none

`include "cpu_macros.svh"

module fetchStage import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   run,
    input  logic                   progWe,
    input  logic [`CPU_IMEM_AW-1:0] progAddr,
    input  logic [`CPU_XLEN-1:0]   progData,
    input  logic                   stall,
    input  logic                   redirect,
    input  logic [`CPU_XLEN-1:0]   redirectPc,
    output ifIdS                   ifId
);

    logic [31:0]          imem [2**`CPU_IMEM_AW];
    logic [`CPU_XLEN-1:0] pc;
    logic [31:0]          fetchWord;

    // program load only while halted
    always_ff @(posedge clk) begin
        if (progWe && !run) begin
            imem[progAddr] <= progData;
        end
    end

    assign fetchWord = imem[pc[`CPU_IMEM_AW+1:2]];  // word index, byte offset dropped

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;  // restart from 0 when run rises
        end else if (redirect) begin
            pc <= redirectPc;  // taken branch wins over a stall
        end else if (!stall) begin
            pc <= pc + `CPU_XLEN'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifId <= '0;
        end else if (!run || redirect) begin
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId.valid <= 1'b1;
            ifId.pc    <= pc;
            ifId.instr <= fetchWord;
        end
        // on stall IF/ID holds for one more cycle
    end

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
// instruction decode with register file, control, immediates, load-use stall and ID/EX register
`default_nettype none

`include "cpu_macros.svh"

module decodeStage import cpuPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  ifIdS  ifId,
    input  memWbS memWb,
    input  idExS  idExCur,
    input  logic  redirect,
    output logic  stall,
    output idExS  idEx
);

    logic [`CPU_XLEN-1:0] regs [32];
    opcodeE               opcode;
    logic [2:0]           funct3;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    logic                 usesRs2;
    logic                 wbWrite;
    logic [`CPU_XLEN-1:0] rs1Data;
    logic [`CPU_XLEN-1:0] rs2Data;
    logic [`CPU_XLEN-1:0] immI;
    logic [`CPU_XLEN-1:0] immS;
    logic [`CPU_XLEN-1:0] immB;
    ctrlS                 ctrl;
    idExS                 idExNext;

    assign opcode = opcodeE'(ifId.instr[6:0]);
    assign funct3 = ifId.instr[14:12];
    assign rs1    = ifId.instr[19:15];
    assign rs2    = ifId.instr[24:20];
    assign rd     = ifId.instr[11:7];

    // funct3 to ALU operation, shared by R and I types
    function automatic aluOpE aluFromFunct3(input logic [2:0] f3, input logic isSub);
        aluOpE op;
        case (f3)
            3'b000:  op = isSub ? aluSub : aluAdd;
            3'b010:  op = aluSlt;
            3'b100:  op = aluXor;
            3'b110:  op = aluOr;
            3'b111:  op = aluAnd;
            default: op = aluAdd;
        endcase
        return op;
    endfunction

    assign wbWrite = memWb.valid && memWb.regWrite && (memWb.rd != 5'd0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[memWb.rd] <= memWb.wbData;
        end
    end

    // write-first bypass, x0 reads as zero
    assign rs1Data = (rs1 == 5'd0) ? '0 :
                     (wbWrite && memWb.rd == rs1) ? memWb.wbData : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 :
                     (wbWrite && memWb.rd == rs2) ? memWb.wbData : regs[rs2];

    assign immI = {{20{ifId.instr[31]}}, ifId.instr[31:20]};
    assign immS = {{20{ifId.instr[31]}}, ifId.instr[31:25], ifId.instr[11:7]};
    assign immB = {{19{ifId.instr[31]}}, ifId.instr[31], ifId.instr[7],
                   ifId.instr[30:25], ifId.instr[11:8], 1'b0};

    always_comb begin
        ctrl    = '0;  // unknown opcodes do nothing
        usesRs2 = 1'b0;
        case (opcode)
            opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromFunct3(funct3, ifId.instr[30]);
                usesRs2       = 1'b1;
            end
            opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluFromFunct3(funct3, 1'b0);  // no subi
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                usesRs2       = 1'b1;
            end
            opBranch: begin
                ctrl.branch = 1'b1;  // compared in execute
                usesRs2     = 1'b1;
            end
            default: ;
        endcase
    end

    // load in ID/EX feeding the instruction in decode
    assign stall = idExCur.valid && idExCur.ctrl.memRead && (idExCur.rd != 5'd0)
                   && ifId.valid
                   && ((idExCur.rd == rs1) || (usesRs2 && idExCur.rd == rs2));

    always_comb begin
        idExNext         = '0;
        idExNext.valid   = ifId.valid && !stall && !redirect;  // bubble on hazard or flush
        idExNext.ctrl    = ctrl;
        idExNext.pc      = ifId.pc;
        idExNext.rs1Data = rs1Data;
        idExNext.rs2Data = rs2Data;
        idExNext.rs1     = rs1;
        idExNext.rs2     = rs2;
        idExNext.rd      = rd;
        case (opcode)
            opStore:  idExNext.imm = immS;
            opBranch: idExNext.imm = immB;
            default:  idExNext.imm = immI;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
// execute stage with operand forwarding, ALU, branch resolution and the EX/MEM register
`default_nettype none

`include "cpu_macros.svh"

module executeStage import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  idExS                 idEx,
    input  memWbS                memWb,
    output exMemS                exMem,
    output logic                 redirect,
    output logic [`CPU_XLEN-1:0] redirectPc
);

    logic [`CPU_XLEN-1:0] opA;
    logic [`CPU_XLEN-1:0] opBReg;  // forwarded rs2, also store data
    logic [`CPU_XLEN-1:0] opB;
    logic [`CPU_XLEN-1:0] aluResult;

    // priority EX/MEM, then MEM/WB, then register file value
    function automatic logic [`CPU_XLEN-1:0] forward(
        input logic [4:0]           rs,
        input logic [`CPU_XLEN-1:0] regVal,
        input exMemS                em,
        input memWbS                wb
    );
        logic [`CPU_XLEN-1:0] val;
        val = regVal;
        if (rs != 5'd0) begin
            if (em.valid && em.regWrite && em.rd == rs) begin
                val = em.aluResult;  // never a load, stall covers that
            end else if (wb.valid && wb.regWrite && wb.rd == rs) begin
                val = wb.wbData;
            end
        end
        return val;
    endfunction

    assign opA    = forward(idEx.rs1, idEx.rs1Data, exMem, memWb);
    assign opBReg = forward(idEx.rs2, idEx.rs2Data, exMem, memWb);
    assign opB    = idEx.ctrl.aluSrc ? idEx.imm : opBReg;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluSlt:  aluResult = {{(`CPU_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    // beq taken, resolved here
    assign redirect   = idEx.valid && idEx.ctrl.branch && (opA == opBReg);
    assign redirectPc = idEx.pc + idEx.imm;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.memToReg  <= idEx.ctrl.memToReg;
            exMem.memRead   <= idEx.ctrl.memRead;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.aluResult <= aluResult;
            exMem.storeData <= opBReg;
            exMem.rd        <= idEx.rd;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memoryStage.sv ====
// data memory access, MEM/WB register, write-back select and the retire trace port
`default_nettype none

`include "cpu_macros.svh"

module memoryStage import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  exMemS                exMem,
    output memWbS                memWb,
    output logic                 retireValid,
    output logic [4:0]           retireRd,
    output logic [`CPU_XLEN-1:0] retireData
);

    logic [`CPU_XLEN-1:0]   dmem [2**`CPU_DMEM_AW];
    logic [`CPU_DMEM_AW-1:0] wordAddr;
    logic [`CPU_XLEN-1:0]   loadData;

    assign wordAddr = exMem.aluResult[`CPU_DMEM_AW+1:2];  // word addressed, byte offset dropped

    always_ff @(posedge clk) begin
        if (exMem.valid && exMem.memWrite) begin
            dmem[wordAddr] <= exMem.storeData;
        end
    end

    assign loadData = exMem.memRead ? dmem[wordAddr] : '0;  // async read

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWb <= '0;
        end else begin
            memWb.valid    <= exMem.valid;
            memWb.regWrite <= exMem.regWrite;
            memWb.rd       <= exMem.rd;
            memWb.wbData   <= exMem.memToReg ? loadData : exMem.aluResult;
        end
    end

    // x0 writes are dropped from the trace
    assign retireValid = memWb.valid && memWb.regWrite && (memWb.rd != 5'd0);
    assign retireRd    = memWb.rd;
    assign retireData  = memWb.wbData;

endmodule

`default_nettype wire

// ==== logic/cpuPipeline.sv ====
// top level of the five-stage core, connects fetch, decode, execute and memory stages
`default_nettype none

`include "cpu_macros.svh"

module cpuPipeline import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    run,
    input  logic                    progWe,
    input  logic [`CPU_IMEM_AW-1:0] progAddr,
    input  logic [`CPU_XLEN-1:0]    progData,
    output logic                    retireValid,
    output logic [4:0]              retireRd,
    output logic [`CPU_XLEN-1:0]    retireData
);

    ifIdS                 ifId;
    idExS                 idEx;
    exMemS                exMem;
    memWbS                memWb;
    logic                 stall;
    logic                 redirect;
    logic [`CPU_XLEN-1:0] redirectPc;

    fetchStage fetchStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .ifId       (ifId)
    );

    decodeStage decodeStage_i (
        .clk      (clk),
        .arstN    (arstN),
        .ifId     (ifId),
        .memWb    (memWb),
        .idExCur  (idEx),  // for load-use check
        .redirect (redirect),
        .stall    (stall),
        .idEx     (idEx)
    );

    executeStage executeStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .idEx       (idEx),
        .memWb      (memWb),
        .exMem      (exMem),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    memoryStage memoryStage_i (
        .clk         (clk),
        .arstN       (arstN),
        .exMem       (exMem),
        .memWb       (memWb),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

endmodule

`default_nettype wire

// ==== tests/cpuPipeline_properties.sv ====
// assertions on the retire port and hazard control of the core, bound into the top level
`default_nettype none

`include "cpu_macros.svh"

module cpuPipeline_properties (
    input logic                 clk,
    input logic                 arstN,
    input logic                 run,
    input logic                 retireValid,
    input logic [4:0]           retireRd,
    input logic [`CPU_XLEN-1:0] retireData,
    input logic                 stall,
    input logic                 redirect
);

    // fetch to write-back takes four edges after run rises
    retireAfterFill: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |-> $past(run, 4))
        else $error("retirement arrived before the pipeline could fill");

    noRetireWhileHalted: assert property (@(posedge clk) disable iff (!arstN)
        !run |-> !retireValid)
        else $error("retirement seen while run is low");

    retireDataKnown: assert property (@(posedge clk) disable iff (!arstN)
        retireValid |-> !$isunknown({retireRd, retireData}))
        else $error("retired rd or data holds unknown bits");

    // hazard and flush controls
    controlKnown: assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown({stall, redirect}))
        else $error("stall or redirect is unknown");

endmodule

bind cpuPipeline cpuPipeline_properties properties_i (
    .clk         (clk),
    .arstN       (arstN),
    .run         (run),
    .retireValid (retireValid),
    .retireRd    (retireRd),
    .retireData  (retireData),
    .stall       (stall),
    .redirect    (redirect)
);

`default_nettype wire

// ==== tests/cpuPipelineTb.sv ====
// testbench for the pipelined core, loads the program from the stimulus file and checks retirements
`default_nettype none

`include "cpu_macros.svh"

module cpuPipelineTb;

    logic                    clk;
    logic                    arstN;
    logic                    run;
    logic                    progWe;
    logic [`CPU_IMEM_AW-1:0] progAddr;
    logic [`CPU_XLEN-1:0]    progData;
    logic                    retireValid;
    logic [4:0]              retireRd;
    logic [`CPU_XLEN-1:0]    retireData;

    logic [`CPU_IMEM_AW-1:0] progAddrQ [$];
    logic [`CPU_XLEN-1:0]    progWordQ [$];
    logic [4:0]              expRdQ [$];
    logic [`CPU_XLEN-1:0]    expDataQ [$];

    cpuPipeline cpuPipeline_i (
        .clk         (clk),
        .arstN       (arstN),
        .run         (run),
        .progWe      (progWe),
        .progAddr    (progAddr),
        .progData    (progData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    always #5 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("CHECK FAILED at time %0t: %s = 0x%08h, expected 0x%08h",
                              $time, name, actual, expected));
        end
    endtask

    // P lines are program words, E lines are expected register writes in order
    task automatic readStimulus;
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        logic [31:0] fieldA;
        logic [31:0] fieldB;
        fd = $fopen("tests/program_stimulus.txt", "r");
        if (fd == 0) begin
            failRun("cannot open the stimulus file tests/program_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h %h", tag, fieldA, fieldB);  // comment lines give n < 3
            if (n == 3 && tag == "P") begin
                progAddrQ.push_back(fieldA[`CPU_IMEM_AW-1:0]);
                progWordQ.push_back(fieldB);
            end else if (n == 3 && tag == "E") begin
                expRdQ.push_back(fieldA[4:0]);
                expDataQ.push_back(fieldB);
            end
        end
        $fclose(fd);
        if (progWordQ.size() == 0 || expDataQ.size() == 0) begin
            failRun("the stimulus file holds no program words or no expected writes");
        end
    endtask

    // retire port must stay silent for this many cycles
    task automatic expectQuiet(input int count);
        repeat (count) begin
            @(negedge clk);
            checkValue("retireValid", 32'(retireValid), 32'd0);
        end
    endtask

    task automatic waitRetire(input int index);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);  // outputs settled since the last rising edge
            cycles++;
        end while (!retireValid && cycles < 200);
        if (!retireValid) begin
            failRun($sformatf("no retirement arrived within 200 cycles for expected write %0d",
                              index));
        end
    endtask

    initial begin
        int seedVal;
        int idleCycles;
        int i;
        clk      = 1'b0;
        arstN    = 1'b0;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        seedVal  = $urandom(32'hff69_bfca);
        readStimulus();
        repeat (3) begin
            @(posedge clk);
        end
        @(negedge clk);
        checkValue("retireValid", 32'(retireValid), 32'd0);
        arstN = 1'b1;
        for (i = 0; i < progWordQ.size(); i++) begin
            progWe   = 1'b1;
            progAddr = progAddrQ[i];
            progData = progWordQ[i];
            @(negedge clk);
            checkValue("retireValid", 32'(retireValid), 32'd0);  // halted while loading
        end
        progWe     = 1'b0;
        idleCycles = int'($urandom % 8);
        expectQuiet(idleCycles);
        run = 1'b1;
        foreach (expRdQ[k]) begin
            waitRetire(k);
            checkValue("retireRd", 32'(retireRd), 32'(expRdQ[k]));
            checkValue("retireData", retireData, expDataQ[k]);
        end
        expectQuiet(50);  // core now spins in the final branch
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/program_stimulus.txt ====
# P <imem word address hex> <instruction word hex>
# E <rd hex> <expected write data hex>, in retirement order
P 00 00500093
P 01 FFD00113
P 02 002081B3
P 03 40118233
P 04 0020F2B3
P 05 00126333
P 06 0030C3B3
P 07 00112433
P 08 0020A4B3
P 09 00708013
P 0A 00100533
P 0B 00702423
P 0C 00802583
P 0D 00158633
P 0E 00A08663
P 0F 06300693
P 10 06200713
P 11 00208463
P 12 00100793
P 13 00278813
P 14 00000063
P 15 00000013
P 16 00000013
E 01 00000005
E 02 FFFFFFFD
E 03 00000002
E 04 FFFFFFFD
E 05 00000005
E 06 FFFFFFFD
E 07 00000007
E 08 00000001
E 09 00000000
E 0A 00000005
E 0B 00000007
E 0C 0000000C
E 0F 00000001
E 10 00000003

// ==== flist.f ====
+incdir+logic
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpuPipeline.sv
tests/cpuPipeline_properties.sv
tests/cpuPipelineTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpuPipelineTb -f flist.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result"; exit 1; }
echo "run passed"
